// ==== rtl/vga_pkg.sv ====
/* shared definitions for the vga frame buffer
   640x480 timing, read pipeline latency and clear colour
   coordinate, address, pixel and output channel types */
`default_nettype none

package vga_pkg;

        // ==================================================
        // horizontal timing, counted in pixels
        // ==================================================
        localparam int H_ACTIVE = 640;
        localparam int H_FRONT  = 16;
        localparam int H_SYNC   = 96;    // hs low for this many cycles
        localparam int H_BACK   = 48;
        localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;   // 800

        // ==================================================
        // vertical timing, counted in lines
        // ==================================================
        localparam int V_ACTIVE = 480;
        localparam int V_FRONT  = 10;
        localparam int V_SYNC   = 2;     // vs low for whole lines
        localparam int V_BACK   = 33;
        localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;   // 525

        // scan coordinate to colour at the pins
        localparam int READ_LATENCY = 2;

        // coordinates and memory address
        typedef logic [9:0]  coord_x_t;  // 0..799 over a line
        typedef logic [8:0]  coord_y_t;  // visible lines only
        typedef logic [18:0] fb_addr_t;  // {x, y}, x in the upper bits

        // colour
        typedef logic [7:0]  pixel_t;    // rrr_ggg_bb
        typedef logic [7:0]  chan_t;     // one dac channel

        localparam pixel_t CLEAR_COLOR = 8'h00;   // black

endpackage

`default_nettype wire

// ==== rtl/vga_write_ctrl.sv ====
/* write port control for the frame buffer
   clear sweep over the visible area, host writes in between */
`timescale 1ns/10ps
`default_nettype none

module vga_write_ctrl (
        input  logic              vga_ctrl_clk,
        input  logic              reset,
        input  logic              clear,
        input  logic              wr_valid,
        output logic              wr_ready,
        input  vga_pkg::coord_x_t wr_x,
        input  vga_pkg::coord_y_t wr_y,
        input  vga_pkg::pixel_t   wr_color,
        output logic              mem_we,
        output vga_pkg::fb_addr_t mem_addr,
        output vga_pkg::pixel_t   mem_data
);
        import vga_pkg::*;

        typedef enum logic {
                ST_SWEEP,      // filling the frame with CLEAR_COLOR
                ST_HOST        // taking host writes
        } state_t;

        state_t   state;
        coord_x_t sweep_x;     // clear position, x steps fastest
        coord_y_t sweep_y;
        logic     sweep_last;
        logic     host_fire;
        logic     host_in_range;

        // ==================================================
        // handshake and decodes
        // ==================================================
        assign wr_ready      = (state == ST_HOST);   // only back-pressure is a sweep
        assign host_fire     = wr_valid & wr_ready;
        assign host_in_range = (wr_x < coord_x_t'(H_ACTIVE)) &&
                               (wr_y < coord_y_t'(V_ACTIVE));   // else dropped
        assign sweep_last    = (sweep_x == coord_x_t'(H_ACTIVE - 1)) &&
                               (sweep_y == coord_y_t'(V_ACTIVE - 1));

        // ==================================================
        // fsm, sweep counters and write enable
        // ==================================================
        always_ff @(posedge vga_ctrl_clk)
        begin
                if (reset)
                begin
                        state   <= ST_SWEEP;   // clear starts straight out of reset
                        sweep_x <= '0;
                        sweep_y <= '0;
                        mem_we  <= 1'b0;
                end
                else
                begin
                        case (state)
                        ST_SWEEP:
                        begin
                                mem_we <= 1'b1;   // one pixel per cycle
                                if (sweep_last)
                                begin
                                        state   <= ST_HOST;
                                        sweep_x <= '0;   // ready for the next clear
                                        sweep_y <= '0;
                                end
                                else if (sweep_x == coord_x_t'(H_ACTIVE - 1))
                                begin
                                        sweep_x <= '0;
                                        sweep_y <= sweep_y + 1'b1;   // next row
                                end
                                else
                                begin
                                        sweep_x <= sweep_x + 1'b1;
                                end
                        end
                        ST_HOST:
                        begin
                                mem_we <= host_fire & host_in_range;
                                // requests during a sweep never get here
                                if (clear)
                                        state <= ST_SWEEP;
                        end
                        default:
                        begin
                                state  <= ST_SWEEP;
                                mem_we <= 1'b0;
                        end
                        endcase
                end
        end

        // address and data follow the source that owns the port
        always_ff @(posedge vga_ctrl_clk)
        begin
                if (state == ST_SWEEP)
                begin
                        mem_addr <= {sweep_x, sweep_y};
                        mem_data <= CLEAR_COLOR;
                end
                else
                begin
                        mem_addr <= {wr_x, wr_y};   // x over y, as the read side
                        mem_data <= wr_color;
                end
        end

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
/* pixel memory, one write port and one registered read port
   read address built from the scan coordinates */
`timescale 1ns/10ps
`default_nettype none

module frame_buffer (
        input  logic              vga_ctrl_clk,
        input  logic              we,
        input  vga_pkg::fb_addr_t wr_addr,
        input  vga_pkg::pixel_t   wr_data,
        input  vga_pkg::coord_x_t rd_x,
        input  vga_pkg::coord_y_t rd_y,
        output vga_pkg::pixel_t   rd_pixel
);
        import vga_pkg::*;

        // full x/y address space, only 640x480 of it is ever shown
        pixel_t   mem [2**$bits(fb_addr_t)];
        fb_addr_t rd_addr;

        assign rd_addr = {rd_x, rd_y};   // same packing as the write side

        // ==================================================
        // write port
        // ==================================================
        always_ff @(posedge vga_ctrl_clk)
        begin
                if (we)
                        mem[wr_addr] <= wr_data;
        end

        // ==================================================
        // read port
        // ==================================================
        // read-before-write on a collision, new data one cycle later
        always_ff @(posedge vga_ctrl_clk)
        begin
                rd_pixel <= mem[rd_addr];
        end

endmodule

`default_nettype wire

// ==== rtl/vga_timing.sv ====
/* 640x480 raster timing
   line and frame counters, active area and sync decodes */
`timescale 1ns/10ps
`default_nettype none

module vga_timing (
        input  logic              vga_ctrl_clk,
        input  logic              reset,
        output vga_pkg::coord_x_t scan_x,
        output vga_pkg::coord_y_t scan_y,
        output logic              scan_active,
        output logic              scan_hs,
        output logic              scan_vs
);
        import vga_pkg::*;

        coord_x_t   h_cnt;     // pixel within the line, 0..799
        logic [9:0] v_cnt;     // line within the frame, 0..524
        logic       h_end;
        logic       v_end;
        logic       h_vis;
        logic       v_vis;
        logic       h_sync_win;
        logic       v_sync_win;

        // ==================================================
        // counters
        // ==================================================
        assign h_end = (h_cnt == coord_x_t'(H_TOTAL - 1));
        assign v_end = (v_cnt == 10'(V_TOTAL - 1));

        always_ff @(posedge vga_ctrl_clk)
        begin
                if (reset)
                begin
                        h_cnt <= '0;   // frame starts on the first visible pixel
                        v_cnt <= '0;
                end
                else
                begin
                        if (h_end)
                        begin
                                h_cnt <= '0;
                                // vertical steps once per line
                                if (v_end)
                                        v_cnt <= '0;
                                else
                                        v_cnt <= v_cnt + 1'b1;
                        end
                        else
                        begin
                                h_cnt <= h_cnt + 1'b1;
                        end
                end
        end

        // ==================================================
        // decodes
        // ==================================================
        assign h_vis = (h_cnt < coord_x_t'(H_ACTIVE));
        assign v_vis = (v_cnt < 10'(V_ACTIVE));

        // sync pulses sit after the front porch
        assign h_sync_win = (h_cnt >= coord_x_t'(H_ACTIVE + H_FRONT)) &&
                            (h_cnt <  coord_x_t'(H_ACTIVE + H_FRONT + H_SYNC));
        assign v_sync_win = (v_cnt >= 10'(V_ACTIVE + V_FRONT)) &&
                            (v_cnt <  10'(V_ACTIVE + V_FRONT + V_SYNC));

        assign scan_x      = h_cnt;
        assign scan_y      = v_cnt[8:0];   // upper bit only set in vertical blanking
        assign scan_active = h_vis & v_vis;
        assign scan_hs     = ~h_sync_win;  // active low
        assign scan_vs     = ~v_sync_win;  // active low, whole lines

endmodule

`default_nettype wire

// ==== rtl/pixel_out.sv ====
/* output stage
   flag delay to match the memory read, colour widening and blanking */
`timescale 1ns/10ps
`default_nettype none

module pixel_out (
        input  logic            vga_ctrl_clk,
        input  logic            reset,
        input  vga_pkg::pixel_t rd_pixel,
        input  logic            scan_active,
        input  logic            scan_hs,
        input  logic            scan_vs,
        output vga_pkg::chan_t  vga_r,
        output vga_pkg::chan_t  vga_g,
        output vga_pkg::chan_t  vga_b,
        output logic            vga_hs,
        output logic            vga_vs,
        output logic            vga_blank_n
);
        import vga_pkg::*;

        // {active, hs, vs} waiting for the memory, last stage is the output
        logic [2:0] flag_dly [READ_LATENCY-1];
        logic       dly_active;

        assign dly_active = flag_dly[READ_LATENCY-2][2];

        // ==================================================
        // stage 1, flags line up with rd_pixel
        // ==================================================
        always_ff @(posedge vga_ctrl_clk)
        begin
                if (reset)
                begin
                        for (int i = 0; i < READ_LATENCY - 1; i++)
                                flag_dly[i] <= 3'b011;   // blanked, syncs idle high
                end
                else
                begin
                        flag_dly[0] <= {scan_active, scan_hs, scan_vs};
                        for (int i = 1; i < READ_LATENCY - 1; i++)
                                flag_dly[i] <= flag_dly[i-1];
                end
        end

        // ==================================================
        // stage 2, registered pins
        // ==================================================
        always_ff @(posedge vga_ctrl_clk)
        begin
                if (reset)
                begin
                        vga_r       <= '0;
                        vga_g       <= '0;
                        vga_b       <= '0;
                        vga_hs      <= 1'b1;
                        vga_vs      <= 1'b1;
                        vga_blank_n <= 1'b0;
                end
                else
                begin
                        // stored bits on top, zeros below
                        vga_r       <= dly_active ? {rd_pixel[7:5], 5'b0} : '0;
                        vga_g       <= dly_active ? {rd_pixel[4:2], 5'b0} : '0;
                        vga_b       <= dly_active ? {rd_pixel[1:0], 6'b0} : '0;
                        vga_hs      <= flag_dly[READ_LATENCY-2][1];
                        vga_vs      <= flag_dly[READ_LATENCY-2][0];
                        vga_blank_n <= dly_active;   // high only in the visible area
                end
        end

endmodule

`default_nettype wire

// ==== rtl/vga_frame_top.sv ====
/* frame buffer top level
   write control, pixel memory, scan timing and output stage */
`timescale 1ns/10ps
`default_nettype none

module vga_frame_top (
        input  logic              vga_ctrl_clk,
        input  logic              reset,
        input  logic              clear,       // one cycle, starts a sweep
        // host pixel port
        input  logic              wr_valid,
        output logic              wr_ready,
        input  vga_pkg::coord_x_t wr_x,
        input  vga_pkg::coord_y_t wr_y,
        input  vga_pkg::pixel_t   wr_color,
        // display side
        output vga_pkg::chan_t    vga_r,
        output vga_pkg::chan_t    vga_g,
        output vga_pkg::chan_t    vga_b,
        output logic              vga_hs,
        output logic              vga_vs,
        output logic              vga_blank_n
);
        import vga_pkg::*;

        // memory write port
        logic     mem_we;
        fb_addr_t mem_addr;
        pixel_t   mem_data;

        // scan side
        coord_x_t scan_x;
        coord_y_t scan_y;
        logic     scan_active;
        logic     scan_hs;
        logic     scan_vs;
        pixel_t   rd_pixel;    // one cycle behind scan_x/scan_y

        vga_write_ctrl i_write_ctrl (
                .vga_ctrl_clk (vga_ctrl_clk),
                .reset        (reset),
                .clear        (clear),
                .wr_valid     (wr_valid),
                .wr_ready     (wr_ready),
                .wr_x         (wr_x),
                .wr_y         (wr_y),
                .wr_color     (wr_color),
                .mem_we       (mem_we),
                .mem_addr     (mem_addr),
                .mem_data     (mem_data)
        );

        frame_buffer i_frame_buffer (
                .vga_ctrl_clk (vga_ctrl_clk),
                .we           (mem_we),
                .wr_addr      (mem_addr),
                .wr_data      (mem_data),
                .rd_x         (scan_x),
                .rd_y         (scan_y),
                .rd_pixel     (rd_pixel)
        );

        vga_timing i_timing (
                .vga_ctrl_clk (vga_ctrl_clk),
                .reset        (reset),
                .scan_x       (scan_x),
                .scan_y       (scan_y),
                .scan_active  (scan_active),
                .scan_hs      (scan_hs),
                .scan_vs      (scan_vs)
        );

        pixel_out i_pixel_out (
                .vga_ctrl_clk (vga_ctrl_clk),
                .reset        (reset),
                .rd_pixel     (rd_pixel),
                .scan_active  (scan_active),
                .scan_hs      (scan_hs),
                .scan_vs      (scan_vs),
                .vga_r        (vga_r),
                .vga_g        (vga_g),
                .vga_b        (vga_b),
                .vga_hs       (vga_hs),
                .vga_vs       (vga_vs),
                .vga_blank_n  (vga_blank_n)
        );

endmodule

`default_nettype wire

// ==== tests/tb_vga_frame.sv ====
/* directed testbench for the vga frame buffer
   reset and clear, sync geometry, host writes, re-clear under back-pressure
   frame scanner checked against a pixel model */
`timescale 1ns/10ps
`default_nettype none

module tb_vga_frame;
        import vga_pkg::*;

        localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;   // 307200
        localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;     // 420000
        localparam int CLEAR_LIMIT  = 310000;                 // cycles allowed for a sweep

        logic     vga_ctrl_clk;
        logic     reset;
        logic     clear;
        logic     wr_valid;
        logic     wr_ready;
        coord_x_t wr_x;
        coord_y_t wr_y;
        pixel_t   wr_color;
        chan_t    vga_r;
        chan_t    vga_g;
        chan_t    vga_b;
        logic     vga_hs;
        logic     vga_vs;
        logic     vga_blank_n;

        pixel_t   model [FRAME_PIXELS];   // expected frame, raster order
        int       mismatches;
        int       failures;               // timeouts and geometry errors

        vga_frame_top i_dut (
                .vga_ctrl_clk (vga_ctrl_clk),
                .reset        (reset),
                .clear        (clear),
                .wr_valid     (wr_valid),
                .wr_ready     (wr_ready),
                .wr_x         (wr_x),
                .wr_y         (wr_y),
                .wr_color     (wr_color),
                .vga_r        (vga_r),
                .vga_g        (vga_g),
                .vga_b        (vga_b),
                .vga_hs       (vga_hs),
                .vga_vs       (vga_vs),
                .vga_blank_n  (vga_blank_n)
        );

        // 40 ns period
        initial
        begin
                vga_ctrl_clk = 1'b0;
                forever #20 vga_ctrl_clk = ~vga_ctrl_clk;
        end

        // ==================================================
        // helpers
        // ==================================================
        function automatic logic [18:0] pix_index(input int x, input int y);
                return 19'(y * H_ACTIVE + x);   // raster order, not the dut's x/y packing
        endfunction

        function automatic logic sync_level(input bit use_vs);
                return use_vs ? vga_vs : vga_hs;
        endfunction

        task automatic show_mismatch(input string sig, input logic [31:0] got,
                                     input logic [31:0] exp);
                $display("MISMATCH %s: got %0h expected %0h", sig, got, exp);
                mismatches++;
        endtask

        task automatic fill_model(input pixel_t p);
                for (int i = 0; i < FRAME_PIXELS; i++)
                        model[19'(i)] = p;
        endtask

        // returns at a falling edge with wr_ready high, or on timeout
        task automatic wait_ready(input string what, output int cycles);
                cycles = 0;
                while (wr_ready !== 1'b1 && cycles < CLEAR_LIMIT)
                begin
                        @(negedge vga_ctrl_clk);
                        cycles++;
                end
                if (wr_ready !== 1'b1)
                begin
                        $display("timeout: wr_ready still low %0d cycles after %s", cycles, what);
                        failures++;
                end
        endtask

        task automatic wait_vs(input logic level, input string what);
                int n;
                n = 0;
                while (vga_vs !== level && n < FRAME_CYCLES + H_TOTAL)
                begin
                        @(negedge vga_ctrl_clk);
                        n++;
                end
                if (vga_vs !== level)
                begin
                        $display("timeout: vga_vs never went to %0b during %s", level, what);
                        failures++;
                end
        endtask

        task automatic host_write(input int x, input int y, input pixel_t c);
                int waited;
                waited = 0;
                @(posedge vga_ctrl_clk);
                wr_valid <= 1'b1;
                wr_x     <= coord_x_t'(x);
                wr_y     <= coord_y_t'(y);
                wr_color <= c;
                @(negedge vga_ctrl_clk);
                while (wr_ready !== 1'b1 && waited < CLEAR_LIMIT)
                begin
                        @(negedge vga_ctrl_clk);
                        waited++;
                end
                if (wr_ready !== 1'b1)
                begin
                        $display("timeout: host write to (%0d, %0d) never accepted", x, y);
                        failures++;
                end
                @(posedge vga_ctrl_clk);   // transfer happens on this edge
                wr_valid <= 1'b0;
                if (x < H_ACTIVE && y < V_ACTIVE)
                        model[pix_index(x, y)] = c;   // off-screen writes are dropped
        endtask

        // one falling edge of hs or vs, then low width and distance to the next fall
        task automatic measure_pulse(input bit use_vs, input int limit,
                                     output int low_len, output int period);
                int   n;
                bit   found;
                logic prev;
                logic level;
                low_len = 0;
                period  = 0;
                found   = 1'b0;
                n       = 0;
                prev    = sync_level(use_vs);
                while (!found && n < limit)
                begin
                        @(negedge vga_ctrl_clk);
                        n++;
                        level = sync_level(use_vs);
                        found = (prev === 1'b1 && level === 1'b0);
                        prev  = level;
                end
                if (!found)
                begin
                        $display("timeout: no falling edge on %s", use_vs ? "vga_vs" : "vga_hs");
                        failures++;
                end
                n = 0;
                while (found && period == 0 && n < limit)
                begin
                        @(negedge vga_ctrl_clk);
                        n++;
                        level = sync_level(use_vs);
                        if (prev === 1'b0 && level === 1'b1)
                                low_len = n;   // first high sample
                        if (prev === 1'b1 && level === 1'b0)
                                period = n;
                        prev = level;
                end
        endtask

        // ==================================================
        // frame scanner
        // ==================================================
        task automatic scan_frame(input string label);
                int     n;
                int     col;
                int     row;
                int     extra;
                pixel_t p;
                chan_t  exp_r;
                chan_t  exp_g;
                chan_t  exp_b;
                wait_vs(1'b0, label);
                wait_vs(1'b1, label);   // next active cycle is the frame's first pixel
                col = 0;
                row = 0;
                n   = 0;
                while (row < V_ACTIVE && n < FRAME_CYCLES)
                begin
                        @(negedge vga_ctrl_clk);
                        n++;
                        if (vga_blank_n === 1'b1)
                        begin
                                if (col < H_ACTIVE)
                                begin
                                        p     = model[pix_index(col, row)];
                                        exp_r = {p[7:5], 5'b0};   // stored bits on top
                                        exp_g = {p[4:2], 5'b0};
                                        exp_b = {p[1:0], 6'b0};
                                        if (vga_r !== exp_r)
                                                show_mismatch($sformatf("vga_r (%0d,%0d)", col, row),
                                                              32'(vga_r), 32'(exp_r));
                                        if (vga_g !== exp_g)
                                                show_mismatch($sformatf("vga_g (%0d,%0d)", col, row),
                                                              32'(vga_g), 32'(exp_g));
                                        if (vga_b !== exp_b)
                                                show_mismatch($sformatf("vga_b (%0d,%0d)", col, row),
                                                              32'(vga_b), 32'(exp_b));
                                end
                                col++;
                        end
                        else if (col != 0)
                        begin
                                if (col != H_ACTIVE)
                                begin
                                        $display("%s: line %0d was active for %0d cycles, not %0d",
                                                 label, row, col, H_ACTIVE);
                                        failures++;
                                end
                                row++;
                                col = 0;
                        end
                end
                if (row < V_ACTIVE)
                begin
                        $display("timeout: %s saw only %0d active lines", label, row);
                        failures++;
                end
                // nothing more may be active before the next vsync
                extra = 0;
                n     = 0;
                while (vga_vs !== 1'b0 && n < 20 * H_TOTAL)
                begin
                        @(negedge vga_ctrl_clk);
                        n++;
                        if (vga_blank_n === 1'b1)
                                extra++;
                end
                if (extra != 0)
                begin
                        $display("%s: %0d active cycles after line %0d", label, extra, V_ACTIVE - 1);
                        failures++;
                end
        endtask

        // ==================================================
        // directed tests
        // ==================================================
        task automatic reset_and_clear();
                int cycles;
                for (int i = 0; i < 16; i++)
                begin
                        @(posedge vga_ctrl_clk);
                        if (i == 15)
                                reset <= 1'b0;   // 16 edges seen with reset high
                        @(negedge vga_ctrl_clk);
                        if (vga_hs !== 1'b1)
                                show_mismatch("vga_hs in reset", 32'(vga_hs), 32'h1);
                        if (vga_vs !== 1'b1)
                                show_mismatch("vga_vs in reset", 32'(vga_vs), 32'h1);
                        if (vga_blank_n !== 1'b0)
                                show_mismatch("vga_blank_n in reset", 32'(vga_blank_n), 32'h0);
                        if (wr_ready !== 1'b0)
                                show_mismatch("wr_ready in reset", 32'(wr_ready), 32'h0);
                end
                wait_ready("reset", cycles);
                if (wr_ready === 1'b1 && cycles < FRAME_PIXELS)
                begin
                        $display("wr_ready rose after %0d cycles, before the clear could finish",
                                 cycles);
                        failures++;
                end
        endtask

        task automatic sync_geometry();
                int low_len;
                int period;
                measure_pulse(1'b0, 2 * H_TOTAL, low_len, period);
                if (low_len != H_SYNC)
                        show_mismatch("vga_hs low cycles", 32'(low_len), 32'(H_SYNC));
                if (period != H_TOTAL)
                        show_mismatch("vga_hs period", 32'(period), 32'(H_TOTAL));
                measure_pulse(1'b1, FRAME_CYCLES + H_TOTAL, low_len, period);
                if (low_len != V_SYNC * H_TOTAL)
                        show_mismatch("vga_vs low cycles", 32'(low_len), 32'(V_SYNC * H_TOTAL));
                if (period != FRAME_CYCLES)
                        show_mismatch("vga_vs period", 32'(period), 32'(FRAME_CYCLES));
        endtask

        task automatic cleared_frame();
                fill_model(8'h00);   // black everywhere
                scan_frame("cleared frame");
        endtask

        task automatic host_writes();
                int     x;
                int     y;
                pixel_t c;
                for (int k = 0; k < 20; k++)
                begin
                        x = int'($urandom % H_ACTIVE);
                        y = int'($urandom % V_ACTIVE);
                        c = pixel_t'($urandom);
                        host_write(x, y, c);
                end
                host_write(H_ACTIVE + 60, 100, 8'hff);   // right of the visible area
                // column 700 is never shown, so the drop shows up on the write enable
                @(negedge vga_ctrl_clk);
                if (i_dut.mem_we !== 1'b0)
                        show_mismatch("mem_we off-screen write", 32'(i_dut.mem_we), 32'h0);
                scan_frame("host writes");
        endtask

        task automatic reclear_backpressure();
                int cycles;
                @(posedge vga_ctrl_clk);
                clear <= 1'b1;
                @(posedge vga_ctrl_clk);
                clear    <= 1'b0;
                wr_valid <= 1'b1;   // held through the whole sweep
                wr_x     <= 10'd321;
                wr_y     <= 9'd123;
                wr_color <= 8'hab;
                @(negedge vga_ctrl_clk);
                if (wr_ready !== 1'b0)
                        show_mismatch("wr_ready after clear", 32'(wr_ready), 32'h0);
                wait_ready("re-clear", cycles);
                if (wr_ready === 1'b1 && cycles < FRAME_PIXELS)
                begin
                        $display("wr_ready came back after %0d cycles, sweep not done", cycles);
                        failures++;
                end
                @(posedge vga_ctrl_clk);   // held write accepted here
                wr_valid <= 1'b0;
                fill_model(8'h00);
                model[pix_index(321, 123)] = 8'hab;
                scan_frame("re-clear");
        endtask

        // ==================================================
        // main sequence
        // ==================================================
        initial
        begin
                reset      = 1'b1;
                clear      = 1'b0;
                wr_valid   = 1'b0;
                wr_x       = '0;
                wr_y       = '0;
                wr_color   = '0;
                mismatches = 0;
                failures   = 0;
                void'($urandom(32'h1d58_4c20));
                reset_and_clear();
                sync_geometry();
                cleared_frame();
                host_writes();
                reclear_backpressure();
                $display("mismatches: %0d, other failures: %0d", mismatches, failures);
                if (mismatches == 0 && failures == 0)
                        $display("Done: no errors");
                else
                        $display("Done: errors found");
                $finish;
        end

endmodule

`default_nettype wire

// ==== vga_frame_top.f ====
rtl/vga_pkg.sv
rtl/vga_write_ctrl.sv
rtl/frame_buffer.sv
rtl/vga_timing.sv
rtl/pixel_out.sv
rtl/vga_frame_top.sv
tests/tb_vga_frame.sv

// ==== Makefile ====
# Verilator build and run of the vga frame buffer testbench

TOP = tb_vga_frame
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 -f vga_frame_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Done: no errors" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
